// File: Bender.yml
package:
  name: fragment_pipeline

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fragmentPkg.sv
      - hdl/tileBuffer.sv
      - hdl/fragmentFetch.sv
      - hdl/fragmentTests.sv
      - hdl/colorBlender.sv
      - hdl/writeBack.sv
      - hdl/fragmentPipeline.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/fragmentPipeline_assert.sv
      - testbench/fragmentPipelineTb.sv

// File: hdl/colorBlender.sv
/*
 * Two-stage color blender.
 * Stage one multiplies source and destination by their factors per
 * channel, stage two adds, rounds and saturates back to 4 bits.
 */
`timescale 1ns/1ps
`default_nettype none
`include "fragment_config.svh"

module colorBlender
(
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             testedValid,
    input  wire fragmentPkg::fetched_t      tested,
    input  wire                             colorWrite,
    input  wire                             depthWrite,
    input  wire fragmentPkg::blendFactor_t  srcFactor,
    input  wire fragmentPkg::blendFactor_t  dstFactor,
    output logic                            blendedValid,
    output logic [`FB_INDEX_WIDTH-1:0]      blendedIndex,
    output logic [`DEPTH_WIDTH-1:0]         blendedDepth,
    output fragmentPkg::color_t             blendedColor,
    output logic                            blendedColorWrite,
    output logic                            blendedDepthWrite
);
    localparam int SPW = `SUB_PIXEL_WIDTH;

    // channels as vectors, r in the top slot
    logic [3:0][SPW-1:0]   srcVec;
    logic [3:0][SPW-1:0]   dstVec;
    logic [3:0][SPW-1:0]   srcFactorVec;
    logic [3:0][SPW-1:0]   dstFactorVec;
    logic [3:0][2*SPW-1:0] srcProduct;
    logic [3:0][2*SPW-1:0] dstProduct;
    logic [3:0][SPW-1:0]   resultVec;

    logic                       productValid;
    logic [`FB_INDEX_WIDTH-1:0] productIndex;
    logic [`DEPTH_WIDTH-1:0]    productDepth;
    logic                       productColorWrite;
    logic                       productDepthWrite;

    assign srcVec = tested.frag.color;
    assign dstVec = tested.dstColor;
    assign srcFactorVec = fragmentPkg::blendFactor(srcFactor, tested.frag.color, tested.dstColor);
    assign dstFactorVec = fragmentPkg::blendFactor(dstFactor, tested.frag.color, tested.dstColor);

    ////////////////////////////////////////////////////////////
    // stage 1, per channel products
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 4; i++)
        begin
            srcProduct[i] <= srcVec[i] * srcFactorVec[i];
            dstProduct[i] <= dstVec[i] * dstFactorVec[i];
        end
        productIndex <= tested.frag.index;
        productDepth <= tested.frag.depth;
        productColorWrite <= colorWrite;
        productDepthWrite <= depthWrite;
    end

    ////////////////////////////////////////////////////////////
    // stage 2, sum, round by +15, saturate on carry
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        logic [2*SPW:0] sum;
        for (int i = 0; i < 4; i++)
        begin
            sum = srcProduct[i] + dstProduct[i] + 9'd15;
            resultVec[i] = sum[2*SPW] ? {SPW{1'b1}} : sum[2*SPW-1:SPW];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            productValid <= 1'b0;
            blendedValid <= 1'b0;
        end
        else
        begin
            productValid <= testedValid;
            blendedValid <= productValid;
        end
        blendedColor <= resultVec;
        blendedIndex <= productIndex;
        blendedDepth <= productDepth;
        blendedColorWrite <= productColorWrite;
        blendedDepthWrite <= productDepthWrite;
    end
endmodule

`default_nettype wire

// File: hdl/fragmentFetch.sv
/*
 * Input stage of the fragment pipeline.
 * Samples the fragment stream, addresses both tile buffers and joins the
 * returned destination color and depth with the fragment they belong to.
 */
`timescale 1ns/1ps
`default_nettype none
`include "fragment_config.svh"

module fragmentFetch
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        fragmentValid,
    input  wire fragmentPkg::fragment_t fragment,
    input  wire fragmentPkg::color_t   dstColor,
    input  wire [`DEPTH_WIDTH-1:0]     dstDepth,
    output logic [`FB_INDEX_WIDTH-1:0] readIndex,
    output logic                       fetchedValid,
    output fragmentPkg::fetched_t      fetched
);
    logic                   sampledValid;
    fragmentPkg::fragment_t sampled;
    fragmentPkg::fragment_t held;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sampledValid <= 1'b0;
            fetchedValid <= 1'b0;
        end
        else
        begin
            sampledValid <= fragmentValid;
            fetchedValid <= sampledValid;
        end
        sampled <= fragment;
        // wait one cycle for the buffer read
        held <= sampled;
    end

    assign readIndex = sampled.index;
    assign fetched = '{frag: held, dstColor: dstColor, dstDepth: dstDepth};
endmodule

`default_nettype wire

// File: hdl/fragmentPipeline.sv
/*
 * Top level of the pixel fragment pipeline.
 * Fetch, depth and alpha tests, blend and write back around the color
 * and depth tile buffers. Every write is visible on the output ports.
 */
`timescale 1ns/1ps
`default_nettype none
`include "fragment_config.svh"

module fragmentPipeline
(
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               fragmentValid,
    input  wire fragmentPkg::fragment_t       fragment,
    input  wire fragmentPkg::pipelineConfig_t pipeConfig,
    output logic                              colorWriteEnable,
    output logic                              depthWriteEnable,
    output logic [`FB_INDEX_WIDTH-1:0]        writeIndex,
    output fragmentPkg::color_t               colorOut,
    output logic [`DEPTH_WIDTH-1:0]           depthOut
);
    logic [`FB_INDEX_WIDTH-1:0] readIndex;
    fragmentPkg::color_t        dstColor;
    logic [`DEPTH_WIDTH-1:0]    dstDepth;
    logic                       fetchedValid;
    fragmentPkg::fetched_t      fetched;
    logic                       testedValid;
    fragmentPkg::fetched_t      tested;
    logic                       colorWrite;
    logic                       depthWrite;
    logic                       blendedValid;
    logic [`FB_INDEX_WIDTH-1:0] blendedIndex;
    logic [`DEPTH_WIDTH-1:0]    blendedDepth;
    fragmentPkg::color_t        blendedColor;
    logic                       blendedColorWrite;
    logic                       blendedDepthWrite;

    fragmentFetch fetch (.*);

    fragmentTests tests (.*);

    colorBlender blender (.*, .srcFactor(pipeConfig.srcFactor), .dstFactor(pipeConfig.dstFactor));

    writeBack write (.*);

    // tile buffers, written back from the output stage
    tileBuffer #(.WIDTH($bits(fragmentPkg::color_t))) colorBuffer (.clk, .readIndex,
        .writeEnable(colorWriteEnable), .writeIndex, .writeData(colorOut), .readData(dstColor));
    tileBuffer #(.WIDTH(`DEPTH_WIDTH)) depthBuffer (.clk, .readIndex,
        .writeEnable(depthWriteEnable), .writeIndex, .writeData(depthOut), .readData(dstDepth));
endmodule

`default_nettype wire

// File: hdl/fragmentPkg.sv
/*
 * Types and helper functions of the fragment pipeline.
 * Fragment, color and configuration structs, the compare and blend
 * factor encodings, and the functions shared by the test and blend stages.
 */
`default_nettype none

package fragmentPkg;
`include "fragment_config.svh"

    typedef struct packed {
        logic [`SUB_PIXEL_WIDTH-1:0] r;
        logic [`SUB_PIXEL_WIDTH-1:0] g;
        logic [`SUB_PIXEL_WIDTH-1:0] b;
        logic [`SUB_PIXEL_WIDTH-1:0] a;
    } color_t;

    typedef struct packed {
        logic [`FB_INDEX_WIDTH-1:0] index;
        logic [`DEPTH_WIDTH-1:0]    depth;
        color_t                     color;
    } fragment_t;

    // compare function, used by both depth and alpha test
    typedef enum logic [2:0] {
        ALWAYS, NEVER, LESS, EQUAL, LEQUAL, GREATER, NOTEQUAL, GEQUAL
    } testFunc_t;

    // codes 11 to 15 behave like ZERO
    typedef enum logic [3:0] {
        ZERO, ONE, SRC_COLOR, ONE_MINUS_SRC_COLOR, DST_COLOR, ONE_MINUS_DST_COLOR,
        SRC_ALPHA, ONE_MINUS_SRC_ALPHA, DST_ALPHA, ONE_MINUS_DST_ALPHA, SRC_ALPHA_SATURATE
    } blendFactor_t;

    typedef struct packed {
        testFunc_t                   depthFunc;
        logic                        depthTestEnable;
        testFunc_t                   alphaFunc;
        logic [`SUB_PIXEL_WIDTH-1:0] alphaRef;
        blendFactor_t                srcFactor;
        blendFactor_t                dstFactor;
    } pipelineConfig_t;

    typedef struct packed {
        fragment_t               frag;
        color_t                  dstColor;
        logic [`DEPTH_WIDTH-1:0] dstDepth;
    } fetched_t;

    ////////////////////////////////////////////////////////////
    // shared functions
    ////////////////////////////////////////////////////////////

    // alpha operands are zero extended by the caller
    function automatic logic testFunc(testFunc_t func, logic [`DEPTH_WIDTH-1:0] value,
                                      logic [`DEPTH_WIDTH-1:0] refValue);
        case (func)
            NEVER: return 1'b0;
            LESS: return value < refValue;
            EQUAL: return value == refValue;
            LEQUAL: return value <= refValue;
            GREATER: return value > refValue;
            NOTEQUAL: return value != refValue;
            GEQUAL: return value >= refValue;
            default: return 1'b1;
        endcase
    endfunction

    // 15 - x is the bitwise inverse on a 4 bit channel
    function automatic color_t blendFactor(blendFactor_t mode, color_t src, color_t dst);
        logic [`SUB_PIXEL_WIDTH-1:0] sat;
        sat = (src.a < ~dst.a) ? src.a : ~dst.a;
        case (mode)
            ONE: return '1;
            SRC_COLOR: return src;
            ONE_MINUS_SRC_COLOR: return ~src;
            DST_COLOR: return dst;
            ONE_MINUS_DST_COLOR: return ~dst;
            SRC_ALPHA: return {4{src.a}};
            ONE_MINUS_SRC_ALPHA: return {4{~src.a}};
            DST_ALPHA: return {4{dst.a}};
            ONE_MINUS_DST_ALPHA: return {4{~dst.a}};
            SRC_ALPHA_SATURATE: return {sat, sat, sat, {`SUB_PIXEL_WIDTH{1'b1}}};
            default: return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: hdl/fragmentTests.sv
/*
 * Depth and alpha test stage.
 * Compares the fragment against the destination depth and the alpha
 * reference, and registers the color and depth write decisions.
 */
`timescale 1ns/1ps
`default_nettype none
`include "fragment_config.svh"

module fragmentTests
(
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               fetchedValid,
    input  wire fragmentPkg::fetched_t        fetched,
    input  wire fragmentPkg::pipelineConfig_t pipeConfig,
    output logic                              testedValid,
    output fragmentPkg::fetched_t             tested,
    output logic                              colorWrite,
    output logic                              depthWrite
);
    localparam int PAD = `DEPTH_WIDTH - `SUB_PIXEL_WIDTH;

    logic depthPassed;
    logic alphaPassed;
    logic colorPass;

    assign depthPassed = fragmentPkg::testFunc(pipeConfig.depthFunc, fetched.frag.depth,
                                               fetched.dstDepth);
    assign alphaPassed = fragmentPkg::testFunc(pipeConfig.alphaFunc,
                                               {{PAD{1'b0}}, fetched.frag.color.a},
                                               {{PAD{1'b0}}, pipeConfig.alphaRef});

    // a disabled depth test always lets the color through
    assign colorPass = alphaPassed && (depthPassed || !pipeConfig.depthTestEnable);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            testedValid <= 1'b0;
        end
        else
        begin
            testedValid <= fetchedValid;
        end
        tested <= fetched;
        colorWrite <= colorPass;
        depthWrite <= colorPass && pipeConfig.depthTestEnable;
    end
endmodule

`default_nettype wire

// File: hdl/fragment_config.svh
/*
 * Sizes shared by the fragment pipeline RTL and its testbench.
 * Include this wherever a width or the pipeline latency is needed.
 */
`ifndef FRAGMENT_CONFIG_SVH
`define FRAGMENT_CONFIG_SVH

// tile buffer index, 256 pixels
`define FB_INDEX_WIDTH 8

// depth value width
`define DEPTH_WIDTH 16

// one color channel of RGBA4444
`define SUB_PIXEL_WIDTH 4

// edges from sampling a fragment to its write outputs
`define PIPELINE_LATENCY 5

`endif

// File: hdl/tileBuffer.sv
/*
 * On-chip tile memory with one registered read port and one write port.
 * Instantiated once for color and once for depth.
 */
`timescale 1ns/1ps
`default_nettype none
`include "fragment_config.svh"

module tileBuffer
#(
    parameter int WIDTH = 16
)
(
    input  wire                       clk,
    input  wire [`FB_INDEX_WIDTH-1:0] readIndex,
    input  wire                       writeEnable,
    input  wire [`FB_INDEX_WIDTH-1:0] writeIndex,
    input  wire [WIDTH-1:0]           writeData,
    output logic [WIDTH-1:0]          readData
);
    logic [WIDTH-1:0] memory [2**`FB_INDEX_WIDTH];

    // a read of the index being written returns the old word
    always_ff @(posedge clk)
    begin
        if (writeEnable)
        begin
            memory[writeIndex] <= writeData;
        end
        readData <= memory[readIndex];
    end
endmodule

`default_nettype wire

// File: hdl/writeBack.sv
/*
 * Output stage of the fragment pipeline.
 * Registers the final write and gates both enables with valid. The
 * outputs drive the top ports and the tile buffer write ports.
 */
`timescale 1ns/1ps
`default_nettype none
`include "fragment_config.svh"

module writeBack
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        blendedValid,
    input  wire [`FB_INDEX_WIDTH-1:0]  blendedIndex,
    input  wire [`DEPTH_WIDTH-1:0]     blendedDepth,
    input  wire fragmentPkg::color_t   blendedColor,
    input  wire                        blendedColorWrite,
    input  wire                        blendedDepthWrite,
    output logic                       colorWriteEnable,
    output logic                       depthWriteEnable,
    output logic [`FB_INDEX_WIDTH-1:0] writeIndex,
    output fragmentPkg::color_t        colorOut,
    output logic [`DEPTH_WIDTH-1:0]    depthOut
);
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            colorWriteEnable <= 1'b0;
            depthWriteEnable <= 1'b0;
        end
        else
        begin
            colorWriteEnable <= blendedValid && blendedColorWrite;
            depthWriteEnable <= blendedValid && blendedDepthWrite;
        end
        // data only moves with a valid fragment
        if (blendedValid)
        begin
            writeIndex <= blendedIndex;
            colorOut <= blendedColor;
            depthOut <= blendedDepth;
        end
    end
endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/fragmentPkg.sv
hdl/tileBuffer.sv
hdl/fragmentFetch.sv
hdl/fragmentTests.sv
hdl/colorBlender.sv
hdl/writeBack.sv
hdl/fragmentPipeline.sv
testbench/fragmentPipeline_assert.sv
testbench/fragmentPipelineTb.sv

// File: testbench/fragmentPipelineTb.sv
/*
 * Testbench for the fragment pipeline.
 * Drives random fragments through six phases (clear, depth test, depth
 * disabled, alpha test, blending, back-to-back), predicts every write
 * with a model over shadow buffers and checks it at the write ports.
 */
`timescale 1ns/1ps
`default_nettype none
`include "fragment_config.svh"

module fragmentPipelineTb;
    localparam int TOTAL_FRAGMENTS = 736;
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_FRAGMENTS + 200;

    typedef struct packed {
        logic [31:0]                dueCycle;
        logic                       depthWrite;
        logic [`FB_INDEX_WIDTH-1:0] index;
        fragmentPkg::color_t        color;
        logic [`DEPTH_WIDTH-1:0]    depth;
    } expectedWrite_t;

    logic                         clk;
    logic                         reset;
    logic                         fragmentValid;
    fragmentPkg::fragment_t       fragment;
    fragmentPkg::pipelineConfig_t pipeConfig;
    logic                         colorWriteEnable;
    logic                         depthWriteEnable;
    logic [`FB_INDEX_WIDTH-1:0]   writeIndex;
    fragmentPkg::color_t          colorOut;
    logic [`DEPTH_WIDTH-1:0]      depthOut;

    int                      cycle = 0;
    logic [31:0]             lcgState = 32'h11f3_f934;
    fragmentPkg::color_t     shadowColor [2**`FB_INDEX_WIDTH];
    logic [`DEPTH_WIDTH-1:0] shadowDepth [2**`FB_INDEX_WIDTH];
    expectedWrite_t          expectedWrites [$];
    logic [`FB_INDEX_WIDTH-1:0] recentIndices [$];

    fragmentPipeline fragmentPipeline_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////////////////////////
    // error reporting and the reference model
    ////////////////////////////////////////////////////////////
    task automatic abortRun(string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compareValue(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected)
            abortRun($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    endtask

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic bit compareHolds(fragmentPkg::testFunc_t func, int value, int refValue);
        case (func)
            fragmentPkg::NEVER: return 1'b0;
            fragmentPkg::LESS: return value < refValue;
            fragmentPkg::EQUAL: return value == refValue;
            fragmentPkg::LEQUAL: return value <= refValue;
            fragmentPkg::GREATER: return value > refValue;
            fragmentPkg::NOTEQUAL: return value != refValue;
            fragmentPkg::GEQUAL: return value >= refValue;
            default: return 1'b1;
        endcase
    endfunction

    // channel 3 is red, channel 0 is alpha
    function automatic int factorFor(fragmentPkg::blendFactor_t mode, logic [15:0] src,
                                     logic [15:0] dst, int ch);
        int s;
        int d;
        int limit;
        s = src[ch*4 +: 4];
        d = dst[ch*4 +: 4];
        limit = (src[3:0] < 15 - dst[3:0]) ? src[3:0] : 15 - dst[3:0];
        case (mode)
            fragmentPkg::ONE: return 15;
            fragmentPkg::SRC_COLOR: return s;
            fragmentPkg::ONE_MINUS_SRC_COLOR: return 15 - s;
            fragmentPkg::DST_COLOR: return d;
            fragmentPkg::ONE_MINUS_DST_COLOR: return 15 - d;
            fragmentPkg::SRC_ALPHA: return src[3:0];
            fragmentPkg::ONE_MINUS_SRC_ALPHA: return 15 - src[3:0];
            fragmentPkg::DST_ALPHA: return dst[3:0];
            fragmentPkg::ONE_MINUS_DST_ALPHA: return 15 - dst[3:0];
            fragmentPkg::SRC_ALPHA_SATURATE: return (ch == 0) ? 15 : limit;
            default: return 0;
        endcase
    endfunction

    function automatic fragmentPkg::color_t blendColor(logic [15:0] src, logic [15:0] dst);
        logic [15:0] result;
        int sum;
        for (int ch = 0; ch < 4; ch++)
        begin
            sum = src[ch*4 +: 4] * factorFor(pipeConfig.srcFactor, src, dst, ch)
                + dst[ch*4 +: 4] * factorFor(pipeConfig.dstFactor, src, dst, ch) + 15;
            result[ch*4 +: 4] = (sum >= 256) ? 4'hf : sum[7:4];
        end
        return result;
    endfunction

    function automatic fragmentPkg::pipelineConfig_t makeConfig(int depthFunc, bit depthOn,
        int alphaFunc, logic [3:0] alphaRef, int srcMode, int dstMode);
        fragmentPkg::pipelineConfig_t conf;
        conf.depthFunc = fragmentPkg::testFunc_t'(depthFunc);
        conf.depthTestEnable = depthOn;
        conf.alphaFunc = fragmentPkg::testFunc_t'(alphaFunc);
        conf.alphaRef = alphaRef;
        conf.srcFactor = fragmentPkg::blendFactor_t'(srcMode);
        conf.dstFactor = fragmentPkg::blendFactor_t'(dstMode);
        return conf;
    endfunction

    function automatic bit recentlyUsed(logic [`FB_INDEX_WIDTH-1:0] index);
        foreach (recentIndices[i])
            if (recentIndices[i] == index)
                return 1'b1;
        return 1'b0;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    task automatic sendFragment(logic [`FB_INDEX_WIDTH-1:0] index, logic [`DEPTH_WIDTH-1:0] depth,
                                fragmentPkg::color_t color);
        bit depthOk;
        bit colorWrite;
        expectedWrite_t write;
        depthOk = compareHolds(pipeConfig.depthFunc, depth, shadowDepth[index]);
        colorWrite = compareHolds(pipeConfig.alphaFunc, color.a, pipeConfig.alphaRef)
            && (depthOk || !pipeConfig.depthTestEnable);
        if (colorWrite)
        begin
            write.dueCycle = cycle + `PIPELINE_LATENCY + 1;
            write.depthWrite = pipeConfig.depthTestEnable;
            write.index = index;
            write.color = blendColor(color, shadowColor[index]);
            write.depth = depth;
            expectedWrites.push_back(write);
            shadowColor[index] = write.color;
            if (write.depthWrite)
                shadowDepth[index] = depth;
        end
        recentIndices.push_back(index);
        if (recentIndices.size() > 8)
            void'(recentIndices.pop_front());
        fragmentValid = 1'b1;
        fragment = '{index: index, depth: depth, color: color};
        @(posedge clk);
        #1 fragmentValid = 1'b0;
    endtask

    // a quarter of the depths repeat the stored one so EQUAL can pass
    task automatic randomFragment(bit allowGap);
        logic [31:0] r;
        logic [`FB_INDEX_WIDTH-1:0] index;
        logic [`DEPTH_WIDTH-1:0] depth;
        do
        begin
            r = lcgNext();
            index = r[23:16];
        end
        while (recentlyUsed(index));
        r = lcgNext();
        depth = (r[25:24] == 2'd0) ? shadowDepth[index] : r[31:16];
        r = lcgNext();
        sendFragment(index, depth, r[31:16]);
        r = lcgNext();
        if (allowGap && r[20])
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // let the pipeline drain before the configuration moves
    task automatic changeConfig(fragmentPkg::pipelineConfig_t conf);
        repeat (8) @(posedge clk);
        #1 pipeConfig = conf;
    endtask

    ////////////////////////////////////////////////////////////
    // write port monitor and timeout
    ////////////////////////////////////////////////////////////
    always @(negedge clk)
    begin
        if (cycle > TIMEOUT_CYCLES)
            abortRun("timeout, the run did not finish in time");
        else if (fragmentPipeline_i.checks.failCount != 0)
            abortRun("an assertion on the write ports failed");
        else if (!reset && (colorWriteEnable || depthWriteEnable))
        begin
            if (expectedWrites.size() == 0)
                abortRun("a write enable was high while no write was expected");
            else
            begin
                compareValue("write cycle", cycle, expectedWrites[0].dueCycle);
                compareValue("colorWriteEnable", colorWriteEnable, 1'b1);
                compareValue("depthWriteEnable", depthWriteEnable, expectedWrites[0].depthWrite);
                compareValue("writeIndex", writeIndex, expectedWrites[0].index);
                compareValue("colorOut", colorOut, expectedWrites[0].color);
                compareValue("depthOut", depthOut, expectedWrites[0].depth);
                void'(expectedWrites.pop_front());
            end
        end
        else if (expectedWrites.size() != 0 && expectedWrites[0].dueCycle < cycle)
            abortRun("an expected write did not appear on the write ports");
    end

    initial
    begin
        logic [31:0] r;
        logic [31:0] s;
        reset = 1'b1;
        fragmentValid = 1'b0;
        fragment = '0;
        pipeConfig = makeConfig(fragmentPkg::ALWAYS, 1'b1, fragmentPkg::ALWAYS, 4'h0,
                                fragmentPkg::ONE, fragmentPkg::ZERO);
        foreach (shadowColor[i])
        begin
            shadowColor[i] = '0;
            shadowDepth[i] = '0;
        end
        // tile memories power up unknown, so hold the destination color at
        // zero until the clear has written every index once
        force fragmentPipeline_i.dstColor = 16'h0000;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;

        for (int i = 0; i < 2**`FB_INDEX_WIDTH; i++)
        begin
            r = lcgNext();
            s = lcgNext();
            sendFragment(i[`FB_INDEX_WIDTH-1:0], r[31:16], s[31:16]);
        end

        for (int f = 0; f < 8; f++)
        begin
            changeConfig(makeConfig(f, 1'b1, fragmentPkg::ALWAYS, 4'h0,
                                    fragmentPkg::ONE, fragmentPkg::ZERO));
            release fragmentPipeline_i.dstColor;
            repeat (16) randomFragment(1'b1);
        end

        changeConfig(makeConfig(fragmentPkg::NEVER, 1'b0, fragmentPkg::ALWAYS, 4'h0,
                                fragmentPkg::ONE, fragmentPkg::ZERO));
        repeat (32) randomFragment(1'b1);

        for (int f = 0; f < 8; f++)
        begin
            r = lcgNext();
            changeConfig(makeConfig(fragmentPkg::ALWAYS, 1'b1, f, r[19:16],
                                    fragmentPkg::ONE, fragmentPkg::ZERO));
            repeat (12) randomFragment(1'b1);
        end

        // first pair uses SRC_ALPHA_SATURATE, second an unused code
        for (int p = 0; p < 10; p++)
        begin
            r = lcgNext();
            changeConfig(makeConfig(fragmentPkg::ALWAYS, 1'b1, fragmentPkg::ALWAYS, 4'h0,
                (p == 0) ? fragmentPkg::SRC_ALPHA_SATURATE : r[19:16],
                (p == 1) ? 13 : r[23:20]));
            repeat (16) randomFragment(1'b1);
        end

        r = lcgNext();
        changeConfig(makeConfig(fragmentPkg::LESS, 1'b1, fragmentPkg::GEQUAL, r[19:16],
                                fragmentPkg::SRC_ALPHA, fragmentPkg::ONE_MINUS_SRC_ALPHA));
        repeat (64) randomFragment(1'b0);

        repeat (8) @(posedge clk);
        if (expectedWrites.size() != 0)
            abortRun("expected writes were still pending at the end of the run");
        else if (fragmentPipeline_i.checks.failCount != 0)
            abortRun("assertions on the write ports failed");
        else
        begin
            $display("All checks passed");
            $finish;
        end
    end
endmodule

`default_nettype wire

// File: testbench/fragmentPipeline_assert.sv
/*
 * Concurrent checks on the write ports of the fragment pipeline.
 * Bound into every fragmentPipeline instance. failCount holds the
 * number of failed assertions.
 */
`timescale 1ns/1ps
`default_nettype none
`include "fragment_config.svh"

module fragmentPipeline_assert
(
    input wire clk,
    input wire reset,
    input wire fragmentValid,
    input wire colorWriteEnable,
    input wire depthWriteEnable
);
    int failCount = 0;

    // the enable set at edge 5 is sampled one edge later
    enableFollowsFragment: assert property (@(posedge clk) disable iff (reset)
        colorWriteEnable |-> $past(fragmentValid, `PIPELINE_LATENCY + 1))
    else
    begin
        failCount++;
        $error("color write without a fragment %0d cycles earlier", `PIPELINE_LATENCY);
    end

    depthNeedsColor: assert property (@(posedge clk) disable iff (reset)
        depthWriteEnable |-> colorWriteEnable)
    else
    begin
        failCount++;
        $error("depth write without a color write");
    end

    enablesKnown: assert property (@(posedge clk) disable iff (reset)
        !$isunknown({colorWriteEnable, depthWriteEnable}))
    else
    begin
        failCount++;
        $error("write enable is unknown");
    end
endmodule

bind fragmentPipeline fragmentPipeline_assert checks (.*);

`default_nettype wire
